//--- src/dout_pkg.sv
// shared constants and types for the digital output controller
// address fields, hold-time width, control-word and write-bus structs, detector states

package dout_pkg;

    // channel count and timer width
    localparam int num_chan = 4;                    // digital output channels
    localparam int time_w   = 16;                   // width of one hold time in clocks

    // register map
    localparam logic [3:0] addr_main     = 4'h0;    // waddr[15:12] for main register space
    localparam logic [3:0] reg_digiout   = 4'h6;    // set register offset, channel field 0
    localparam logic [3:0] off_dout_ctrl = 4'h9;    // control word offset, channel field 1..4

    // per-channel control word
    // upper half is the high time, lower half the low time
    // a zero time holds the output at its level
    typedef struct packed {
        logic [time_w-1:0] hi_time;                 // clocks to stay high, minus one
        logic [time_w-1:0] lo_time;                 // clocks to stay low, minus one
    } dout_times_t;

    // single-cycle register write bus
    typedef struct packed {
        logic [15:0] waddr;                         // space, channel field, offset
        logic [31:0] wdata;                         // write payload
        logic        wen;                           // one-cycle write strobe
    } reg_wr_t;

    // board revision detection
    typedef enum logic [1:0] {
        cfg_check  = 2'd0,                          // pins released, still sampling
        cfg_legacy = 2'd1,                          // both pins pulled high, older board
        cfg_bidir  = 2'd2                           // both pins pulled low, bidirectional board
    } cfg_state_t;

endpackage

//--- src/dout_reg_port.sv
// register port for the digital output controller
// write decode into per-channel set/control strobes, control-word read mux

`timescale 1ns/1ns

module dout_reg_port (
    input  dout_pkg::reg_wr_t                  reg_wr,         // write bus from outside
    input  logic [15:0]                        raddr,          // read address
    input  logic                               cfg_bidir,      // bidir board, invert set values
    input  dout_pkg::dout_times_t              times [dout_pkg::num_chan], // words from timers
    output logic [dout_pkg::num_chan-1:0]      set_en,         // per-channel set strobe
    output logic [dout_pkg::num_chan-1:0]      set_val,        // new output level per channel
    output logic [dout_pkg::num_chan-1:0]      ctrl_en,        // per-channel control write
    output dout_pkg::dout_times_t              ctrl_word,      // control word for all channels
    output logic [31:0]                        rdata           // combinational read data
);

    logic       in_main;        // write hits the main register space
    logic [3:0] wr_chan;        // write channel field
    logic [3:0] wr_off;         // write offset field
    logic       set_hit;        // write to the set register
    logic       ctrl_hit;       // write to some control word
    logic [3:0] rd_chan;        // read channel field
    logic       rd_ctrl;        // read offset is a control word

    // field split of the write address
    assign in_main = reg_wr.wen && (reg_wr.waddr[15:12] == dout_pkg::addr_main);
    assign wr_chan = reg_wr.waddr[7:4];
    assign wr_off  = reg_wr.waddr[3:0];

    // set register lives at channel field 0 only
    assign set_hit  = in_main && (wr_chan == 4'd0) && (wr_off == dout_pkg::reg_digiout);
    assign ctrl_hit = in_main && (wr_off == dout_pkg::off_dout_ctrl);

    // every channel sees the same payload, ctrl_en picks who takes it
    assign ctrl_word = dout_pkg::dout_times_t'(reg_wr.wdata);

    always_comb begin
        for (int i = 0; i < dout_pkg::num_chan; i++) begin
            set_en[i]  = set_hit && reg_wr.wdata[8+i];          // mask in wdata[11:8]
            // older board inverted in hardware, keep that polarity on the new one
            set_val[i] = reg_wr.wdata[i] ^ cfg_bidir;
            ctrl_en[i] = ctrl_hit && (wr_chan == 4'(i + 1));    // channel i is field i+1
        end
    end

    // read side, no space check here
    assign rd_chan = raddr[7:4];
    assign rd_ctrl = (raddr[3:0] == dout_pkg::off_dout_ctrl);

    always_comb begin
        rdata = 32'd0;                                          // field 0, 5+ and others read 0
        for (int i = 0; i < dout_pkg::num_chan; i++) begin
            if (rd_ctrl && (rd_chan == 4'(i + 1))) begin
                rdata = times[i];
            end
        end
    end

endmodule

//--- src/dout_timer.sv
// one digital output channel
// control word register, hold-time counter and the output bit

`timescale 1ns/1ns

module dout_timer (
    input  logic                   sysclk,
    input  logic                   reset,          // sync, active low
    input  logic                   set_en,         // force dout to set_val
    input  logic                   set_val,        // level for a set write
    input  logic                   ctrl_en,        // load ctrl_word
    input  dout_pkg::dout_times_t  ctrl_word,      // new hi/lo times
    output dout_pkg::dout_times_t  times,          // current word for readback
    output logic                   dout            // output bit
);

    dout_pkg::dout_times_t          times_q;        // stored hi/lo times
    logic [dout_pkg::time_w-1:0]    count;          // clocks spent at current level
    logic [dout_pkg::time_w-1:0]    hold_time;      // time for the present level

    // high level counts against hi_time, low level against lo_time
    assign hold_time = dout ? times_q.hi_time : times_q.lo_time;
    assign times     = times_q;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            dout    <= 1'b0;
            times_q <= '0;
            count   <= '0;
        end else if (set_en) begin                  // set wins over a control write
            dout  <= set_val;
            count <= '0;                            // restart the hold
        end else if (ctrl_en) begin
            times_q <= ctrl_word;
            count   <= '0;                          // new word also restarts
        end else if (hold_time != '0) begin
            // count 0..hold_time, so the level lasts hold_time+1 clocks
            if (count == hold_time) begin
                dout  <= ~dout;
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
        // zero hold time keeps dout and count where they are
    end

endmodule

//--- src/dout_cfg_fsm.sv
// board revision detector
// samples the released direction pins and decides legacy or bidirectional board

`timescale 1ns/1ns

module dout_cfg_fsm (
    input  logic sysclk,
    input  logic reset,             // sync, active low
    input  logic dir12_in,          // level on dir12 while released
    input  logic dir34_in,          // level on dir34 while released
    output logic dir_drive,         // level for both direction pins
    output logic cfg_valid,         // detection finished
    output logic cfg_bidir          // bidirectional board found
);

    dout_pkg::cfg_state_t state;        // current detection state
    dout_pkg::cfg_state_t state_nxt;    // next detection state

    // newer board has pulldowns on the direction lines
    // older board leaves them open and the fpga pullups read high
    always_comb begin
        state_nxt = state;
        case (state)
            dout_pkg::cfg_check: begin
                if (!dir12_in && !dir34_in) begin
                    state_nxt = dout_pkg::cfg_bidir;
                end else if (dir12_in && dir34_in) begin
                    state_nxt = dout_pkg::cfg_legacy;
                end
                // mixed levels, keep checking
            end
            dout_pkg::cfg_legacy: state_nxt = dout_pkg::cfg_legacy;   // final until reset
            dout_pkg::cfg_bidir:  state_nxt = dout_pkg::cfg_bidir;    // final until reset
            default:              state_nxt = dout_pkg::cfg_check;    // unused code, recheck
        endcase
    end

    // outputs decoded from the next state so they follow the leaving edge
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state     <= dout_pkg::cfg_check;
            cfg_valid <= 1'b0;              // releases the pins
            cfg_bidir <= 1'b0;              // assume older board
            dir_drive <= 1'b0;
        end else begin
            state     <= state_nxt;
            cfg_valid <= (state_nxt != dout_pkg::cfg_check);
            cfg_bidir <= (state_nxt == dout_pkg::cfg_bidir);
            dir_drive <= (state_nxt == dout_pkg::cfg_bidir);  // high turns the outputs on
        end
    end

endmodule

//--- src/dout_ctrl_top.sv
// top level of the four-channel digital output controller
// register port, per-channel timers, board detector and direction pin drivers

`timescale 1ns/1ns

module dout_ctrl_top (
    input  logic                            sysclk,
    input  logic                            reset,      // sync, active low
    input  dout_pkg::reg_wr_t               reg_wr,     // single-cycle write bus
    input  logic [15:0]                     raddr,      // read address
    output logic [31:0]                     rdata,      // read data, combinational
    output logic [dout_pkg::num_chan-1:0]   dout,       // digital outputs
    inout  wire                             dir12,      // direction pin, channels 1-2
    inout  wire                             dir34,      // direction pin, channels 3-4
    output logic                            cfg_valid,  // board detection done
    output logic                            cfg_bidir   // bidirectional board
);

    logic [dout_pkg::num_chan-1:0] set_en;              // per-channel set strobes
    logic [dout_pkg::num_chan-1:0] set_val;             // polarity-corrected set levels
    logic [dout_pkg::num_chan-1:0] ctrl_en;             // per-channel control strobes
    dout_pkg::dout_times_t         ctrl_word;           // shared control payload
    dout_pkg::dout_times_t         chan_times [dout_pkg::num_chan]; // readback words
    logic                          dir_drive;           // detector pin level
    logic                          pin_oe;              // drive the direction pins

    // address decode and read mux
    dout_reg_port u_reg_port (
        .reg_wr    (reg_wr),
        .raddr     (raddr),
        .cfg_bidir (cfg_bidir),
        .times     (chan_times),
        .set_en    (set_en),
        .set_val   (set_val),
        .ctrl_en   (ctrl_en),
        .ctrl_word (ctrl_word),
        .rdata     (rdata)
    );

    // one timer per output bit
    for (genvar i = 0; i < dout_pkg::num_chan; i++) begin : g_chan
        dout_timer u_timer (
            .sysclk    (sysclk),
            .reset     (reset),
            .set_en    (set_en[i]),
            .set_val   (set_val[i]),
            .ctrl_en   (ctrl_en[i]),
            .ctrl_word (ctrl_word),
            .times     (chan_times[i]),
            .dout      (dout[i])
        );
    end

    // board revision check on the released pins
    dout_cfg_fsm u_cfg_fsm (
        .sysclk    (sysclk),
        .reset     (reset),
        .dir12_in  (dir12),
        .dir34_in  (dir34),
        .dir_drive (dir_drive),
        .cfg_valid (cfg_valid),
        .cfg_bidir (cfg_bidir)
    );

    // pins stay released through reset and detection
    // only the bidirectional board gets them driven
    assign pin_oe = cfg_valid && cfg_bidir;

    assign dir12 = pin_oe ? dir_drive : 1'bz;   // enables transceiver 1-2
    assign dir34 = pin_oe ? dir_drive : 1'bz;   // enables transceiver 3-4

endmodule

//--- tests/dout_ctrl_tb.sv
// testbench for the digital output controller top level
// replays the case file: register writes, reads, dout timing, board detection

`timescale 1ns/1ns

module dout_ctrl_tb;

    logic                            sysclk;
    logic                            reset;         // sync, active low
    dout_pkg::reg_wr_t               reg_wr;
    logic [15:0]                     raddr;
    logic [31:0]                     rdata;
    logic [dout_pkg::num_chan-1:0]   dout;
    wire                             dir12;
    wire                             dir34;
    logic                            cfg_valid;
    logic                            cfg_bidir;
    logic                            pull12;        // board-side level on dir12
    logic                            pull34;        // board-side level on dir34

    byte             op_q [$];                      // opcode per case line
    logic [31:0]     arg_a [$];                     // first field
    logic [31:0]     arg_b [$];                     // second field
    int unsigned     limit;                         // timeout in cycles, 0 until file is read
    int unsigned     cycles;

    // board pulls are weak, the DUT's strong drive overrides them
    assign (weak0, weak1) dir12 = pull12;
    assign (weak0, weak1) dir34 = pull34;

    dout_ctrl_top dut (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .raddr     (raddr),
        .rdata     (rdata),
        .dout      (dout),
        .dir12     (dir12),
        .dir34     (dir34),
        .cfg_valid (cfg_valid),
        .cfg_bidir (cfg_bidir)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;                // 8 ns period
    end

    // run limit guard
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, act, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic file_error(input string what);
        $display("Case file problem: %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // reads every op line up front so the timeout is known before the run
    task automatic read_cases();
        int          fd;
        int          n;
        string       op;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tests/dout_ctrl_cases.txt", "r");
        if (fd == 0) begin
            file_error("cannot open tests/dout_ctrl_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, " %s", op);
                if (n != 1) break;                  // end of file
                if (op.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd);           // skip comment line
                end else begin
                    case (op)
                        "W", "R": n = $fscanf(fd, " %h %h", a, b);
                        "D":      n = $fscanf(fd, " %d %h", a, b);
                        "P", "V": n = $fscanf(fd, " %d %d", a, b);
                        default:  n = 0;
                    endcase
                    if (n != 2) begin
                        file_error($sformatf("bad line starting with '%s'", op));
                    end else begin
                        op_q.push_back(op.getc(0));
                        arg_a.push_back(a);
                        arg_b.push_back(b);
                        limit += 20;                // per-line allowance
                        if (op == "D") limit += a;
                    end
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) file_error("no operations found in the case file");
        end
    endtask

    // pulls change at the start, reset low for 8 cycles, returns on the first live edge
    task automatic apply_reset(input logic l12, input logic l34);
        @(posedge sysclk);
        reset      <= 1'b0;
        pull12     <= l12;
        pull34     <= l34;
        reg_wr.wen <= 1'b0;
        repeat (8) @(posedge sysclk);
        reset <= 1'b1;
        @(posedge sysclk);                          // detector samples the pins here
    endtask

    // returns on the edge that takes the write
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wr.waddr <= addr;
        reg_wr.wdata <= data;
        reg_wr.wen   <= 1'b1;
        @(posedge sysclk);
        reg_wr.wen   <= 1'b0;                       // single-cycle strobe
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [31:0] exp);
        @(posedge sysclk);
        raddr <= addr;
        @(negedge sysclk);                          // combinational path settled
        check_value($sformatf("rdata[%h]", addr), rdata, exp);
    endtask

    task automatic run_op(input int i);
        case (op_q[i])
            "W": write_reg(arg_a[i][15:0], arg_b[i]);
            "R": read_check(arg_a[i][15:0], arg_b[i]);
            "D": begin
                repeat (arg_a[i]) @(posedge sysclk);
                @(negedge sysclk);
                check_value("dout", dout, arg_b[i]);
            end
            "P": apply_reset(arg_a[i][0], arg_b[i][0]);
            "V": begin
                @(negedge sysclk);
                check_value("cfg_valid", cfg_valid, arg_a[i]);
                check_value("cfg_bidir", cfg_bidir, arg_b[i]);
                // bidir board gets both pins driven high, otherwise the pulls show
                check_value("dir12", dir12, arg_b[i][0] ? 1'b1 : pull12);
                check_value("dir34", dir34, arg_b[i][0] ? 1'b1 : pull34);
            end
            default: file_error("unknown opcode in stored cases");
        endcase
    endtask

    initial begin
        reset     = 1'b0;
        reg_wr    = '0;
        raddr     = 16'd0;
        pull12    = 1'b1;                           // legacy board to start
        pull34    = 1'b1;
        limit     = 0;
        cycles    = 0;
        read_cases();
        apply_reset(1'b1, 1'b1);
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
        end
        repeat (2) @(posedge sysclk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- dout_ctrl.f
src/dout_pkg.sv
src/dout_reg_port.sv
src/dout_timer.sv
src/dout_cfg_fsm.sv
src/dout_ctrl_top.sv
tests/dout_ctrl_tb.sv

//--- Bender.yml
package:
  name: dout_ctrl

sources:
  # package first, the rest depends on it
  - src/dout_pkg.sv
  - src/dout_reg_port.sv
  - src/dout_timer.sv
  - src/dout_cfg_fsm.sv
  - src/dout_ctrl_top.sv

  - target: test
    files:
      - tests/dout_ctrl_tb.sv

//--- tests/dout_ctrl_cases.txt
# W addr data (hex) | R addr rdata (hex) | D wait cycles (dec) dout (hex), offsets from last W
# P dir12 dir34 pull levels, reruns reset | V cfg_valid cfg_bidir
V 1 0
W 0006 00000f05
D 0 5
W 0006 00000a0a
D 0 f
W 0006 00000600
D 0 9
W 0019 11112222
W 0029 33334444
W 0039 55556666
W 0049 77778888
R 0019 11112222
R 0029 33334444
R 0039 55556666
R 0049 77778888
R 0009 00000000
R 0059 00000000
R 0018 00000000
P 1 1
V 1 0
R 0019 00000000
W 0019 00040000
W 0006 00000101
D 0 1
D 4 1
D 1 0
D 20 0
W 0029 00020003
D 0 0
D 3 0
D 1 2
D 2 2
D 1 0
D 3 0
D 1 2
D 2 2
D 1 0
P 1 1
W 0039 00050000
W 0006 00000404
D 3 4
W 0006 00000404
D 0 4
D 5 4
D 1 0
P 0 0
V 1 1
W 0006 00000f05
D 0 a
W 0006 00000300
D 0 b
P 1 0
V 0 0
D 10 0
V 0 0
